/* flow_pkg.sv */
`default_nettype none

package flow_pkg;

   // Generic 32-bit quantity used for addresses, instructions and data.
   typedef logic [31:0] word_t;

   // Serial bit position during the execute phase.
   typedef logic [4:0] cnt_t;

   // Decoded controls that steer the serial datapath.
   typedef struct packed {
      logic jump;
      logic jal_or_jalr;
      logic utype;
      logic pc_rel;
      logic trap;
      logic rd_we;
   } ctrl_t;

   // Payload returned by the fetch responder.
   typedef struct packed {
      word_t insn;
      word_t rs1;
   } fetch_rsp_t;

   // Payload presented on the result port.
   typedef struct packed {
      word_t pc;
      word_t rd;
      logic  rd_we;
      logic  bad_pc;
      logic  trap;
   } result_t;

   typedef enum logic [2:0] {
      IDLE,
      FETCH_REQ,
      FETCH_REL,
      EXEC,
      RES_REQ,
      RES_REL
   } state_t;

   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_AUIPC  = 7'b0010111;
   localparam logic [6:0] OP_JAL    = 7'b1101111;
   localparam logic [6:0] OP_JALR   = 7'b1100111;
   localparam logic [6:0] OP_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire

/* bit_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module bit_counter (
   input  wire  clk,
   input  wire  i_rst,
   input  logic i_pc_en,
   output logic o_cnt0,
   output logic o_cnt2,
   output logic o_cnt12to31,
   output logic o_done
);

   import flow_pkg::*;

   cnt_t cnt;

   // The count wraps from 31 back to 0 on its own, so it is at zero
   // again when the next execute phase starts.
   always_ff @(posedge clk) begin
      if (i_rst) begin
         cnt <= '0;
      end else if (i_pc_en) begin
         cnt <= cnt + cnt_t'(1);
      end
   end

   assign o_cnt0      = (cnt == cnt_t'(0));
   assign o_cnt2      = (cnt == cnt_t'(2));
   assign o_cnt12to31 = (cnt >= cnt_t'(12));
   assign o_done      = (cnt == cnt_t'(31));

   // Every execute phase must begin at bit position 0.
   a_start_at_zero : assert property (
      @(posedge clk) disable iff (i_rst)
      $rose(i_pc_en) |-> (cnt == cnt_t'(0))
   );

endmodule

`default_nettype wire

/* insn_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_decode (
   input  wire             clk,
   input  wire             i_rst,
   input  logic            i_load,
   input  flow_pkg::word_t i_insn,
   output flow_pkg::ctrl_t o_ctrl,
   output flow_pkg::word_t o_imm
);

   import flow_pkg::*;

   logic [6:0] opcode;
   ctrl_t      ctrl_d;
   word_t      imm_d;

   assign opcode = i_insn[6:0];

   always_comb begin
      ctrl_d = '0;
      imm_d  = '0;
      if (i_insn[1:0] != 2'b11) begin
         // Compressed or otherwise illegal encoding.
         ctrl_d.trap = 1'b1;
      end else begin
         case (opcode)
            OP_LUI: begin
               ctrl_d.utype = 1'b1;
               ctrl_d.rd_we = 1'b1;
               imm_d        = {i_insn[31:12], 12'b0};
            end
            OP_AUIPC: begin
               ctrl_d.utype  = 1'b1;
               ctrl_d.pc_rel = 1'b1;
               ctrl_d.rd_we  = 1'b1;
               imm_d         = {i_insn[31:12], 12'b0};
            end
            OP_JAL: begin
               ctrl_d.jump        = 1'b1;
               ctrl_d.jal_or_jalr = 1'b1;
               ctrl_d.pc_rel      = 1'b1;
               ctrl_d.rd_we       = 1'b1;
               imm_d = {{12{i_insn[31]}}, i_insn[19:12], i_insn[20],
                        i_insn[30:21], 1'b0};
            end
            OP_JALR: begin
               // The target comes from rs1 + imm, so the PC is not an operand.
               ctrl_d.jump        = 1'b1;
               ctrl_d.jal_or_jalr = 1'b1;
               ctrl_d.rd_we       = 1'b1;
               imm_d              = {{21{i_insn[31]}}, i_insn[30:20]};
            end
            OP_SYSTEM: begin
               ctrl_d.trap = 1'b1;
            end
            default: begin
               // Everything else just falls through to pc + 4.
               ctrl_d = '0;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_ctrl <= '0;
      end else if (i_load) begin
         o_ctrl <= ctrl_d;
      end
   end

   always_ff @(posedge clk) begin
      if (i_load) begin
         o_imm <= imm_d;
      end
   end

endmodule

`default_nettype wire

/* operand_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_shifter #(
   parameter flow_pkg::word_t TRAP_VECTOR = 32'h0
) (
   input  wire             clk,
   input  wire             i_rst,
   input  logic            i_load,
   input  logic            i_pc_en,
   input  logic            i_cnt0,
   input  flow_pkg::word_t i_rs1,
   input  flow_pkg::word_t i_imm,
   input  logic            i_rd_bit,
   output logic            o_imm_bit,
   output logic            o_buf_bit,
   output logic            o_csr_pc_bit,
   output flow_pkg::word_t o_rd
);

   import flow_pkg::*;

   word_t rs1_sr;
   word_t imm_sr;
   word_t tvec_sr;
   word_t rd_sr;
   logic  carry_r;
   logic  carry_in;
   logic  sum_cy;
   logic  sum_bit;

   // The decoder registers its immediate on the load pulse, so it is
   // only valid from the first serial cycle on. Bit 0 is taken directly
   // and the rest is captured into the shift register in that cycle.
   assign o_imm_bit = i_cnt0 ? i_imm[0] : imm_sr[0];

   always_ff @(posedge clk) begin
      if (i_load) begin
         rs1_sr  <= i_rs1;
         tvec_sr <= TRAP_VECTOR;
      end else if (i_pc_en) begin
         rs1_sr  <= {1'b0, rs1_sr[31:1]};
         tvec_sr <= {1'b0, tvec_sr[31:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_pc_en) begin
         if (i_cnt0) begin
            imm_sr <= {i_imm[31], i_imm[31:1]};
         end else begin
            imm_sr <= {imm_sr[31], imm_sr[31:1]};
         end
      end
   end

   // Serial rs1 + imm. The fetch side zeroes rs1 for anything but JALR,
   // which turns this into a plain copy of the immediate.
   assign carry_in           = carry_r & ~i_cnt0;
   assign {sum_cy, sum_bit}  = {1'b0, rs1_sr[0]} + {1'b0, o_imm_bit} + {1'b0, carry_in};
   assign o_buf_bit          = sum_bit;
   assign o_csr_pc_bit       = tvec_sr[0];

   always_ff @(posedge clk) begin
      if (i_rst) begin
         carry_r <= 1'b0;
      end else begin
         carry_r <= i_pc_en & sum_cy;
      end
   end

   // The rd value arrives LSB first and ends up aligned after 32 shifts.
   always_ff @(posedge clk) begin
      if (i_pc_en) begin
         rd_sr <= {i_rd_bit, rd_sr[31:1]};
      end
   end

   assign o_rd = rd_sr;

endmodule

`default_nettype wire

/* pc_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_ctrl #(
   parameter flow_pkg::word_t RESET_PC = 32'h0
) (
   input  wire             clk,
   input  wire             i_rst,
   input  logic            i_pc_en,
   input  logic            i_cnt0,
   input  logic            i_cnt2,
   input  logic            i_cnt12to31,
   input  flow_pkg::ctrl_t i_ctrl,
   input  logic            i_imm_bit,
   input  logic            i_buf_bit,
   input  logic            i_csr_pc_bit,
   output logic            o_rd_bit,
   output logic            o_bad_pc,
   output flow_pkg::word_t o_ibus_adr
);

   import flow_pkg::*;

   logic pc;
   logic pc_plus_4;
   logic pc_plus_4_cy;
   logic pc_plus_4_cy_r;
   logic pc_plus_offset;
   logic pc_plus_offset_cy;
   logic pc_plus_offset_cy_r;
   logic pc_plus_offset_aligned;
   logic offset_a;
   logic offset_b;
   logic new_pc;
   logic cnt1_r;
   logic bad_pc_r;

   // The current PC bit is always the bottom of the rotating address.
   assign pc = o_ibus_adr[0];

   // Adding 4 means injecting a single one at bit position 2.
   assign {pc_plus_4_cy, pc_plus_4} = {1'b0, pc} + {1'b0, i_cnt2} + {1'b0, pc_plus_4_cy_r};

   // U-type takes the immediate from bit 12 up; jumps use the buffered
   // operand, which already holds imm or rs1 + imm.
   assign offset_a = i_ctrl.pc_rel & pc;
   assign offset_b = i_ctrl.utype ? (i_imm_bit & i_cnt12to31) : i_buf_bit;

   assign {pc_plus_offset_cy, pc_plus_offset} =
      {1'b0, offset_a} + {1'b0, offset_b} + {1'b0, pc_plus_offset_cy_r};

   assign pc_plus_offset_aligned = pc_plus_offset & ~i_cnt0;

   always_comb begin
      if (i_ctrl.trap) begin
         new_pc = i_csr_pc_bit & ~i_cnt0;
      end else if (i_ctrl.jump) begin
         new_pc = pc_plus_offset_aligned;
      end else begin
         new_pc = pc_plus_4;
      end
   end

   assign o_rd_bit = (i_ctrl.utype & pc_plus_offset_aligned) |
                     (i_ctrl.jal_or_jalr & pc_plus_4);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         pc_plus_4_cy_r      <= 1'b0;
         pc_plus_offset_cy_r <= 1'b0;
         cnt1_r              <= 1'b0;
      end else begin
         pc_plus_4_cy_r      <= i_pc_en & pc_plus_4_cy;
         pc_plus_offset_cy_r <= i_pc_en & pc_plus_offset_cy;
         cnt1_r              <= i_pc_en & i_cnt0;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_ibus_adr <= RESET_PC;
      end else if (i_pc_en) begin
         o_ibus_adr <= {new_pc, o_ibus_adr[31:1]};
      end
   end

   // Bit 1 of the target is on the offset adder one cycle after cnt0.
   // The flag is rewritten for every instruction and held until the next.
   always_ff @(posedge clk) begin
      if (i_rst) begin
         bad_pc_r <= 1'b0;
      end else if (i_pc_en && cnt1_r) begin
         bad_pc_r <= i_ctrl.jump & pc_plus_offset;
      end
   end

   assign o_bad_pc = bad_pc_r;

endmodule

`default_nettype wire

/* flow_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module flow_fsm (
   input  wire                  clk,
   input  wire                  i_rst,
   input  logic                 i_ibus_ack,
   input  logic                 i_res_ack,
   input  logic                 i_done,
   input  flow_pkg::fetch_rsp_t i_ibus_rdt,
   input  flow_pkg::ctrl_t      i_ctrl,
   input  logic                 i_bad_pc,
   input  flow_pkg::word_t      i_pc,
   input  flow_pkg::word_t      i_rd,
   output logic                 o_ibus_req,
   output logic                 o_load,
   output logic                 o_pc_en,
   output logic                 o_res_req,
   output flow_pkg::word_t      o_insn,
   output flow_pkg::word_t      o_rs1,
   output flow_pkg::result_t    o_res
);

   import flow_pkg::*;

   state_t state;
   state_t state_nxt;
   word_t  pc_q;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:      state_nxt = FETCH_REQ;
         FETCH_REQ: if (i_ibus_ack) state_nxt = FETCH_REL;
         FETCH_REL: if (!i_ibus_ack) state_nxt = EXEC;
         EXEC:      if (i_done) state_nxt = RES_REQ;
         RES_REQ:   if (i_res_ack) state_nxt = RES_REL;
         RES_REL:   if (!i_res_ack) state_nxt = IDLE;
         default:   state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   assign o_ibus_req = (state == FETCH_REQ);
   assign o_res_req  = (state == RES_REQ);
   assign o_pc_en    = (state == EXEC);

   // Load fires in the last release cycle, right before execution starts.
   assign o_load = (state == FETCH_REL) && !i_ibus_ack;

   // Fetch data is taken while ack is high. Only JALR reads rs1, so for
   // everything else it is zeroed and the serial adder passes imm through.
   always_ff @(posedge clk) begin
      if (o_ibus_req && i_ibus_ack) begin
         o_insn <= i_ibus_rdt.insn;
         if (i_ibus_rdt.insn[6:0] == OP_JALR) begin
            o_rs1 <= i_ibus_rdt.rs1;
         end else begin
            o_rs1 <= '0;
         end
      end
   end

   // The address still points at the fetched instruction here; it starts
   // rotating in the next cycle.
   always_ff @(posedge clk) begin
      if (o_load) begin
         pc_q <= i_pc;
      end
   end

   always_comb begin
      o_res.pc     = pc_q;
      o_res.rd     = i_rd;
      o_res.rd_we  = i_ctrl.rd_we;
      o_res.bad_pc = i_bad_pc;
      o_res.trap   = i_ctrl.trap;
   end

   // Ack may only move toward the level of req, which keeps the four
   // phases of each handshake in order.
   a_ibus_hold : assert property (
      @(posedge clk) disable iff (i_rst)
      $changed(i_ibus_ack) |-> (o_ibus_req == i_ibus_ack)
   );

   a_res_hold : assert property (
      @(posedge clk) disable iff (i_rst)
      $changed(i_res_ack) |-> (o_res_req == i_res_ack)
   );

   // The datapath must not move the fetch address during a request.
   a_adr_stable : assert property (
      @(posedge clk) disable iff (i_rst)
      (o_ibus_req && $past(o_ibus_req)) |-> $stable(i_pc)
   );

endmodule

`default_nettype wire

/* flow_top.sv */
`timescale 1ns/1ps
`default_nettype none

module flow_top #(
   parameter flow_pkg::word_t RESET_PC    = 32'h0000_0000,
   parameter flow_pkg::word_t TRAP_VECTOR = 32'h0000_0100
) (
   input  wire                  clk,
   input  wire                  i_rst,
   output logic                 o_ibus_req,
   output flow_pkg::word_t      o_ibus_adr,
   input  logic                 i_ibus_ack,
   input  flow_pkg::fetch_rsp_t i_ibus_rdt,
   output logic                 o_res_req,
   output flow_pkg::result_t    o_res,
   input  logic                 i_res_ack
);

   import flow_pkg::*;

   logic  load;
   logic  pc_en;
   logic  done;
   logic  cnt0;
   logic  cnt2;
   logic  cnt12to31;
   logic  imm_bit;
   logic  buf_bit;
   logic  csr_pc_bit;
   logic  rd_bit;
   logic  bad_pc;
   ctrl_t ctrl;
   word_t insn;
   word_t rs1;
   word_t imm;
   word_t rd;

   flow_fsm u_fsm (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_ibus_ack (i_ibus_ack),
      .i_res_ack  (i_res_ack),
      .i_done     (done),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ctrl     (ctrl),
      .i_bad_pc   (bad_pc),
      .i_pc       (o_ibus_adr),
      .i_rd       (rd),
      .o_ibus_req (o_ibus_req),
      .o_load     (load),
      .o_pc_en    (pc_en),
      .o_res_req  (o_res_req),
      .o_insn     (insn),
      .o_rs1      (rs1),
      .o_res      (o_res)
   );

   bit_counter u_cnt (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_pc_en     (pc_en),
      .o_cnt0      (cnt0),
      .o_cnt2      (cnt2),
      .o_cnt12to31 (cnt12to31),
      .o_done      (done)
   );

   insn_decode u_dec (
      .clk    (clk),
      .i_rst  (i_rst),
      .i_load (load),
      .i_insn (insn),
      .o_ctrl (ctrl),
      .o_imm  (imm)
   );

   operand_shifter #(
      .TRAP_VECTOR (TRAP_VECTOR)
   ) u_ops (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_load       (load),
      .i_pc_en      (pc_en),
      .i_cnt0       (cnt0),
      .i_rs1        (rs1),
      .i_imm        (imm),
      .i_rd_bit     (rd_bit),
      .o_imm_bit    (imm_bit),
      .o_buf_bit    (buf_bit),
      .o_csr_pc_bit (csr_pc_bit),
      .o_rd         (rd)
   );

   pc_ctrl #(
      .RESET_PC (RESET_PC)
   ) u_pc (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_pc_en      (pc_en),
      .i_cnt0       (cnt0),
      .i_cnt2       (cnt2),
      .i_cnt12to31  (cnt12to31),
      .i_ctrl       (ctrl),
      .i_imm_bit    (imm_bit),
      .i_buf_bit    (buf_bit),
      .i_csr_pc_bit (csr_pc_bit),
      .o_rd_bit     (rd_bit),
      .o_bad_pc     (bad_pc),
      .o_ibus_adr   (o_ibus_adr)
   );

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD_NS  = 10,
   parameter int RST_CYCLES = 16
) (
   output logic o_clk,
   output logic o_rst
);

   initial begin
      o_clk = 1'b0;
      forever #(PERIOD_NS / 2) o_clk = ~o_clk;
   end

   // Reset is released on a falling edge, like every other DUT input.
   initial begin
      o_rst = 1'b1;
      repeat (RST_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_rst = 1'b0;
   end

endmodule

`default_nettype wire

/* tb_flow.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_flow;

   import flow_pkg::*;

   localparam word_t RESET_PC   = 32'h8000_0000;
   localparam word_t TRAP_VEC   = 32'h8000_0100;
   localparam int    RST_CYCLES = 16;
   localparam int    N_RANDOM   = 24;

   typedef enum logic [2:0] {K_LUI, K_AUIPC, K_JAL, K_JALR, K_OTHER, K_TRAP} kind_e;

   // One program step. Address and expected outcome are filled in by the model.
   typedef struct packed {
      kind_e kind;
      word_t imm;
      word_t rs1;
      word_t insn;
      word_t addr;
      word_t next_pc;
      word_t rd;
      logic  rd_we;
      logic  bad_pc;
      logic  trap;
   } step_t;

   wire        clk;
   wire        rst;
   logic       ibus_req;
   word_t      ibus_adr;
   logic       ibus_ack;
   fetch_rsp_t ibus_rdt;
   logic       res_req;
   result_t    res;
   logic       res_ack;

   step_t       tbl[$];
   logic [31:0] rng_state;
   logic        table_built;

   tb_clkgen #(
      .PERIOD_NS  (10),
      .RST_CYCLES (RST_CYCLES)
   ) u_clkgen (
      .o_clk (clk),
      .o_rst (rst)
   );

   flow_top #(
      .RESET_PC    (RESET_PC),
      .TRAP_VECTOR (TRAP_VEC)
   ) uut (
      .clk        (clk),
      .i_rst      (rst),
      .o_ibus_req (ibus_req),
      .o_ibus_adr (ibus_adr),
      .i_ibus_ack (ibus_ack),
      .i_ibus_rdt (ibus_rdt),
      .o_res_req  (res_req),
      .o_res      (res),
      .i_res_ack  (res_ack)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] draw_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1, "Simulation stopped at the first error.");
   endtask

   task automatic expect_equal(input string what, input int idx, input word_t got,
                               input word_t exp);
      assert (got == exp) else
         fail_run($sformatf("Mismatch at %0t ns: step %0d %s is %h, expected %h",
                            $time, idx, what, got, exp));
   endtask

   // Encodes a step and normalizes its immediate to the value the ISA gives it.
   function automatic step_t make_step(input kind_e kind, input word_t imm, input word_t rs1,
                                       input word_t raw);
      step_t s;
      s      = '0;
      s.kind = kind;
      s.rs1  = rs1;
      case (kind)
         K_LUI, K_AUIPC: begin
            s.imm  = {imm[31:12], 12'b0};
            s.insn = {imm[31:12], 5'd3, (kind == K_LUI) ? OP_LUI : OP_AUIPC};
         end
         K_JAL: begin
            s.imm  = {{11{imm[20]}}, imm[20:1], 1'b0};
            s.insn = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OP_JAL};
         end
         K_JALR: begin
            s.imm  = {{20{imm[11]}}, imm[11:0]};
            s.insn = {imm[11:0], 5'd6, 3'b000, 5'd1, OP_JALR};
         end
         default: begin
            s.imm  = '0;
            s.insn = raw;
         end
      endcase
      return s;
   endfunction

   // Reference model of one instruction.
   function automatic step_t predict(input step_t s);
      step_t e;
      word_t target;
      e         = s;
      e.rd      = '0;
      e.rd_we   = 1'b0;
      e.bad_pc  = 1'b0;
      e.trap    = 1'b0;
      e.next_pc = s.addr + 32'd4;
      target    = '0;
      case (s.kind)
         K_LUI: begin
            e.rd    = s.imm;
            e.rd_we = 1'b1;
         end
         K_AUIPC: begin
            e.rd    = s.addr + s.imm;
            e.rd_we = 1'b1;
         end
         K_JAL, K_JALR: begin
            target    = (s.kind == K_JAL) ? s.addr + s.imm : s.rs1 + s.imm;
            e.rd      = s.addr + 32'd4;
            e.rd_we   = 1'b1;
            e.next_pc = {target[31:1], 1'b0};
            e.bad_pc  = target[1];
         end
         K_TRAP: begin
            e.trap    = 1'b1;
            e.next_pc = TRAP_VEC;
         end
         default: begin
         end
      endcase
      return e;
   endfunction

   task automatic build_table();
      logic [31:0] r0;
      logic [31:0] r1;
      logic [31:0] r2;
      logic [31:0] r3;
      logic [6:0]  op;
      word_t       raw;
      word_t       addr;
      kind_e       kind;
      tbl.push_back(make_step(K_LUI,   32'hABCD_E000, draw_rand(), '0));
      tbl.push_back(make_step(K_AUIPC, 32'h1234_5000, draw_rand(), '0));
      tbl.push_back(make_step(K_OTHER, '0, draw_rand(), 32'h0050_0093));
      tbl.push_back(make_step(K_JAL,   32'h0000_0040, draw_rand(), '0));
      tbl.push_back(make_step(K_JAL,   32'hFFFF_FFE0, draw_rand(), '0));
      tbl.push_back(make_step(K_JALR,  32'h0000_0010, 32'h8000_0400, '0));
      // Lands on a target with bit 1 set, so the next steps run misaligned.
      tbl.push_back(make_step(K_JALR,  32'hFFFF_FFFC, 32'h8000_1003, '0));
      tbl.push_back(make_step(K_LUI,   32'h0000_1000, draw_rand(), '0));
      tbl.push_back(make_step(K_JAL,   32'h0000_0102, draw_rand(), '0));
      tbl.push_back(make_step(K_JAL,   32'h0000_0006, draw_rand(), '0));
      tbl.push_back(make_step(K_AUIPC, 32'hFFFF_F000, draw_rand(), '0));
      tbl.push_back(make_step(K_TRAP,  '0, draw_rand(), 32'h0000_0073));
      tbl.push_back(make_step(K_OTHER, '0, draw_rand(), 32'h0011_2223));
      tbl.push_back(make_step(K_TRAP,  '0, draw_rand(), 32'h0010_0073));
      tbl.push_back(make_step(K_TRAP,  '0, draw_rand(), 32'h0000_0000));
      tbl.push_back(make_step(K_TRAP,  '0, draw_rand(), 32'hFFFF_FFFD));
      tbl.push_back(make_step(K_OTHER, '0, draw_rand(), 32'h0040_2083));
      tbl.push_back(make_step(K_JALR,  32'h0000_07FF, 32'h0000_FFFF, '0));
      tbl.push_back(make_step(K_AUIPC, 32'hFFFF_F000, draw_rand(), '0));
      tbl.push_back(make_step(K_OTHER, '0, draw_rand(), 32'h0FF0_000F));
      for (int i = 0; i < N_RANDOM; i++) begin
         r0   = draw_rand();
         r1   = draw_rand();
         r2   = draw_rand();
         r3   = draw_rand();
         kind = kind_e'(3'(r0 % 32'd6));
         case (r3[1:0])
            2'd0:    op = 7'b0010011;
            2'd1:    op = 7'b0110011;
            2'd2:    op = 7'b0000011;
            default: op = 7'b0100011;
         endcase
         if (kind == K_TRAP) begin
            if (r3[0]) begin
               raw = r3[1] ? 32'h0010_0073 : 32'h0000_0073;
            end else begin
               raw = {r3[31:2], 1'b0, r3[2]};
            end
         end else begin
            raw = {r3[31:7], op};
         end
         tbl.push_back(make_step(kind, r1, r2, raw));
      end
      // Each step is fetched from where the previous one sends the PC.
      addr = RESET_PC;
      foreach (tbl[i]) begin
         tbl[i].addr = addr;
         tbl[i]      = predict(tbl[i]);
         addr        = tbl[i].next_pc;
      end
   endtask

   task automatic serve_fetches();
      logic [31:0] st;
      step_t       s;
      st = xorshift32(rng_state ^ 32'h0F0F_0F0F);
      foreach (tbl[i]) begin
         s = tbl[i];
         do @(negedge clk); while (!ibus_req);
         expect_equal("fetch address", i, ibus_adr, s.addr);
         st = xorshift32(st);
         repeat (st % 5) @(negedge clk);
         ibus_ack      = 1'b1;
         ibus_rdt.insn = s.insn;
         ibus_rdt.rs1  = s.rs1;
         do @(negedge clk); while (ibus_req);
         st = xorshift32(st);
         repeat (st % 3) @(negedge clk);
         ibus_ack = 1'b0;
         ibus_rdt = {st, ~st};
      end
      // The fetch after the last step shows where that step sent the PC.
      do @(negedge clk); while (!ibus_req);
      expect_equal("final fetch address", tbl.size(), ibus_adr, tbl[tbl.size() - 1].next_pc);
   endtask

   task automatic consume_results();
      logic [31:0] st;
      step_t       s;
      st = xorshift32(~rng_state);
      foreach (tbl[i]) begin
         s = tbl[i];
         do @(negedge clk); while (!res_req);
         expect_equal("result pc", i, res.pc, s.addr);
         expect_equal("rd_we", i, word_t'(res.rd_we), word_t'(s.rd_we));
         expect_equal("trap", i, word_t'(res.trap), word_t'(s.trap));
         expect_equal("bad_pc", i, word_t'(res.bad_pc), word_t'(s.bad_pc));
         if (s.rd_we) begin
            expect_equal("rd", i, res.rd, s.rd);
         end
         st = xorshift32(st);
         repeat (st % 5) @(negedge clk);
         res_ack = 1'b1;
         do @(negedge clk); while (res_req);
         st = xorshift32(st);
         repeat (st % 3) @(negedge clk);
         res_ack = 1'b0;
      end
   endtask

   initial begin : reset_monitor
      repeat (RST_CYCLES) begin
         @(negedge clk);
         assert (!ibus_req && !res_req) else
            fail_run($sformatf("Mismatch at %0t ns: a request is high during reset", $time));
         expect_equal("reset address", 0, ibus_adr, RESET_PC);
      end
   end

   initial begin : watchdog
      wait (table_built);
      repeat (RST_CYCLES + 100 * tbl.size()) @(posedge clk);
      fail_run("Timeout: the DUT stopped making progress before all steps were done.");
   end

   initial begin : main
      ibus_ack    = 1'b0;
      ibus_rdt    = '0;
      res_ack     = 1'b0;
      table_built = 1'b0;
      rng_state   = 32'h19d6e5ed;
      build_table();
      table_built = 1'b1;
      fork
         serve_fetches();
         consume_results();
      join
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
flow_pkg.sv
bit_counter.sv
insn_decode.sv
operand_shifter.sv
pc_ctrl.sv
flow_fsm.sv
flow_top.sv
tb_clkgen.sv
tb_flow.sv
